//--- verif/cpu_tests.txt
# one block per test: test <name>, prog <count> <hex words>, out <count> <hex port values>
# then inst <hex final num_inst>, optional mem <hex address> <hex word>, closed by end
test alu_fwd
prog 21
4105 F41C 46FD F81C F6C0 FC1C FB01 F01C 6112 5534 F41C
F482 F81C F8C4 FC1C FC05 F046 F783 F8C7 FC1C F01D
out 8 0005 0002 0007 FFFB 1234 1230 EDCF F6F7
inst 0015
end
test load_store
prog 12 61AB 55CD 4220 8900 7B00 FC1C 4F01 8B01 7801 F840 F41C F01D
out 2 ABCD ABEE
inst 000C
mem 0021 ABCE
end
test branches
prog 25
4101 42FF 0503 F41C 0602 F81C F81C 1601 F81C 1A02 F41C F41C 2801
4303 FC1C 2C02 F81C F81C 3401 F81C 3802 F41C F41C F41C F01D
out 5 0001 FFFF 0003 FFFF 0001
inst 0011
end
test jump
prog 12 4107 9005 4501 F41C F01D F41C 9009 F01C F01C 4501 F41C F01D
out 2 0007 0008
inst 0007
end
test halt_stop
prog 6 4109 F41C F01D 8130 F81C 4205
out 1 0009
inst 0003
mem 0030 0000
end
test halt_only
prog 1 F01D
out 0
inst 0001
end

//--- cpu.f
rtl/cpu_pkg.sv
rtl/hazard_ctrl.sv
rtl/fetch_stage.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/cpu_top.sv
verif/tb_memory.sv
verif/cpu_tb.sv

//--- verif/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	localparam test_file     = "verif/cpu_tests.txt";
	localparam int max_tests = 16;
	localparam int max_words = 512;

	logic              clk;
	logic              arst_n;
	logic              imem_read;
	logic [word_w-1:0] imem_addr;
	logic [word_w-1:0] imem_data;
	dmem_req_t         dmem_req;
	logic [word_w-1:0] dmem_rdata;
	logic [word_w-1:0] num_inst;
	logic [word_w-1:0] output_port;
	logic              is_halted;

	string             names      [max_tests];
	int                prog_start [max_tests];
	int                prog_len   [max_tests];
	int                out_start  [max_tests];
	int                out_len    [max_tests];
	logic [word_w-1:0] exp_inst   [max_tests];
	bit                has_mem    [max_tests];
	logic [word_w-1:0] mem_addr   [max_tests];
	logic [word_w-1:0] mem_word   [max_tests];
	logic [word_w-1:0] prog_words [max_words];
	logic [word_w-1:0] out_words  [max_words];
	int                num_tests;
	int                prog_fill;
	int                out_fill;
	int                errors;
	int                checks;
	int                limit_ns;
	bit                tests_loaded;
	string             cur_name;

	cpu_top u_dut (
		.clk(clk), .arst_n(arst_n), .imem_read(imem_read), .imem_addr(imem_addr),
		.imem_data(imem_data), .dmem_req(dmem_req), .dmem_rdata(dmem_rdata),
		.num_inst(num_inst), .output_port(output_port), .is_halted(is_halted)
	);

	tb_memory u_mem (
		.clk(clk), .imem_read(imem_read), .imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_req(dmem_req), .dmem_rdata(dmem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("Error: test %s, %s: expected %0h, actual %0h", cur_name, what,
				expected, actual);
		end
	endtask

	task automatic load_tests();
		int                fd;
		int                n;
		int                cnt;
		string             kw;
		string             text;
		logic [word_w-1:0] word;
		logic [word_w-1:0] addr;
		fd = $fopen(test_file, "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the test file %s", test_file);
		end else begin
			while ($fscanf(fd, "%s", kw) == 1) begin
				if (kw == "#") begin
					n = $fgets(text, fd); // skip the rest of the comment
				end else if (kw == "test") begin
					n = $fscanf(fd, "%s", text);
					names[num_tests]    = text;
					prog_len[num_tests] = 0;
					out_len[num_tests]  = 0;
					has_mem[num_tests]  = 1'b0;
				end else if (kw == "prog") begin
					n = $fscanf(fd, "%d", cnt);
					prog_start[num_tests] = prog_fill;
					prog_len[num_tests]   = cnt;
					repeat (cnt) begin
						n = $fscanf(fd, "%h", word);
						prog_words[prog_fill] = word;
						prog_fill++;
					end
				end else if (kw == "out") begin
					n = $fscanf(fd, "%d", cnt);
					out_start[num_tests] = out_fill;
					out_len[num_tests]   = cnt;
					repeat (cnt) begin
						n = $fscanf(fd, "%h", word);
						out_words[out_fill] = word;
						out_fill++;
					end
				end else if (kw == "inst") begin
					n = $fscanf(fd, "%h", word);
					exp_inst[num_tests] = word;
				end else if (kw == "mem") begin
					n = $fscanf(fd, "%h %h", addr, word);
					has_mem[num_tests]  = 1'b1;
					mem_addr[num_tests] = addr;
					mem_word[num_tests] = word;
				end else if (kw == "end") begin
					num_tests++;
				end else begin
					errors++;
					$display("unknown keyword %s in the test file", kw);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_test(input int t);
		int                i;
		int                seen;
		logic [word_w-1:0] last_port;
		logic [word_w-1:0] exp_port;
		cur_name = names[t];
		@(posedge clk);
		arst_n <= 1'b0;
		@(negedge clk);
		u_mem.clear_all();
		for (i = 0; i < prog_len[t]; i++)
			u_mem.write_code(i, prog_words[prog_start[t] + i]);
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value("num_inst in reset", 0, num_inst);
		check_value("output_port in reset", 0, output_port);
		check_value("is_halted in reset", 0, is_halted);
		check_value("imem_read in reset", 0, imem_read);
		check_value("dmem read and write in reset", 0, {dmem_req.read, dmem_req.write});
		@(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_value("num_inst after reset", 0, num_inst);
		check_value("output_port after reset", 0, output_port);
		check_value("is_halted after reset", 0, is_halted);
		check_value("imem_read after reset", 1, imem_read);
		seen      = 0;
		last_port = output_port;
		while (is_halted !== 1'b1) begin
			@(negedge clk);
			if (output_port !== last_port) begin
				if (seen < out_len[t])
					check_value("output_port", out_words[out_start[t] + seen], output_port);
				seen++;
				last_port = output_port;
			end
		end
		check_value("output_port changes", out_len[t], seen);
		check_value("num_inst at halt", exp_inst[t], num_inst);
		exp_port = '0;
		if (out_len[t] > 0)
			exp_port = out_words[out_start[t] + out_len[t] - 1];
		repeat (10) @(negedge clk);
		check_value("num_inst after halt", exp_inst[t], num_inst);
		check_value("output_port after halt", exp_port, output_port);
		check_value("is_halted after halt", 1, is_halted);
		if (has_mem[t])
			check_value("data memory word", mem_word[t], u_mem.read_data(mem_addr[t]));
	endtask

	initial begin
		int cycles;
		arst_n = 1'b0;
		load_tests();
		cycles = 0;
		for (int t = 0; t < num_tests; t++)
			cycles += 10 * prog_len[t] + 40;
		limit_ns     = cycles * 4;
		tests_loaded = 1'b1;
		if (num_tests == 0) begin
			errors++;
			$display("no tests were read from %s", test_file);
		end
		for (int t = 0; t < num_tests; t++)
			run_test(t);
		$display("tests: %0d, checks: %0d, errors: %0d", num_tests, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// watchdog
	initial begin
		wait (tests_loaded);
		#(limit_ns);
		$display("Timeout: the tests did not finish within %0d ns", limit_ns);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- verif/tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
	input  logic                       clk,
	input  logic                       imem_read,
	input  logic [cpu_pkg::word_w-1:0] imem_addr,
	output logic [cpu_pkg::word_w-1:0] imem_data,
	input  cpu_pkg::dmem_req_t         dmem_req,
	output logic [cpu_pkg::word_w-1:0] dmem_rdata
);
	import cpu_pkg::*;

	localparam int depth = 1 << word_w; // full 16-bit address space

	logic [word_w-1:0] imem [depth];
	logic [word_w-1:0] dmem [depth];

	assign imem_data  = imem_read ? imem[imem_addr] : '0;
	assign dmem_rdata = dmem_req.read ? dmem[dmem_req.address] : '0;

	always @(posedge clk) begin
		if (dmem_req.write)
			dmem[dmem_req.address] <= dmem_req.write_data;
	end

	// zero words decode as BNE r0, r0 which is never taken
	task automatic clear_all();
		for (int i = 0; i < depth; i++) begin
			imem[i] = '0;
			dmem[i] = '0;
		end
	endtask

	task automatic write_code(input logic [word_w-1:0] addr, input logic [word_w-1:0] word);
		imem[addr] = word;
	endtask

	function automatic logic [word_w-1:0] read_data(input logic [word_w-1:0] addr);
		return dmem[addr];
	endfunction

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input  logic                       clk,
	input  logic                       arst_n,
	output logic                       imem_read,
	output logic [cpu_pkg::word_w-1:0] imem_addr,
	input  logic [cpu_pkg::word_w-1:0] imem_data,
	output cpu_pkg::dmem_req_t         dmem_req,
	input  logic [cpu_pkg::word_w-1:0] dmem_rdata,
	output logic [cpu_pkg::word_w-1:0] num_inst,
	output logic [cpu_pkg::word_w-1:0] output_port,
	output logic                       is_halted
);
	import cpu_pkg::*;

	logic [word_w-1:0]     pc_id;
	logic [word_w-1:0]     inst_id;
	logic                  valid_id;
	logic                  stall;
	logic                  flush;
	logic [reg_addr_w-1:0] rs_idx;
	logic [reg_addr_w-1:0] rt_idx;
	logic                  rs_used;
	logic                  rt_used;
	logic [word_w-1:0]     rs_data;
	logic [word_w-1:0]     rt_data;
	id_ex_t                id_ex;
	ex_mem_t               ex_mem;
	mem_wb_t               mem_wb;
	fwd_sel_e              fwd_a;
	fwd_sel_e              fwd_b;
	logic [word_w-1:0]     mem_fwd;
	logic [word_w-1:0]     wb_fwd;
	logic                  wr_en;
	logic [reg_addr_w-1:0] wr_addr;
	logic [word_w-1:0]     wr_data;

	fetch_stage u_fetch (
		.clk(clk), .arst_n(arst_n), .stall(stall), .flush(flush),
		.redirect_pc(ex_mem.target),
		.imem_read(imem_read), .imem_addr(imem_addr), .imem_data(imem_data),
		.pc_id(pc_id), .inst_id(inst_id), .valid_id(valid_id)
	);

	decode_stage u_decode (
		.clk(clk), .arst_n(arst_n), .stall(stall), .flush(flush),
		.pc_id(pc_id), .inst_id(inst_id), .valid_id(valid_id),
		.rs(rs_idx), .rt(rt_idx), .rs_used(rs_used), .rt_used(rt_used),
		.rs_data(rs_data), .rt_data(rt_data), .id_ex(id_ex)
	);

	register_file u_regs (
		.clk(clk), .arst_n(arst_n), .rs(rs_idx), .rt(rt_idx),
		.rs_data(rs_data), .rt_data(rt_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	execute_stage u_execute (
		.clk(clk), .arst_n(arst_n), .flush(flush), .id_ex(id_ex),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .mem_fwd(mem_fwd), .wb_fwd(wb_fwd),
		.ex_mem(ex_mem)
	);

	mem_wb_stage u_mem_wb (
		.clk(clk), .arst_n(arst_n), .ex_mem(ex_mem),
		.dmem_req(dmem_req), .dmem_rdata(dmem_rdata),
		.mem_fwd(mem_fwd), .mem_wb(mem_wb), .wb_fwd(wb_fwd),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.num_inst(num_inst), .output_port(output_port), .is_halted(is_halted)
	);

	hazard_ctrl u_hazard (
		.rs_id(rs_idx), .rt_id(rt_idx), .rs_used(rs_used), .rt_used(rt_used),
		.id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
		.stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

endmodule

//--- rtl/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
	input  logic                           clk,
	input  logic                           arst_n,
	input  cpu_pkg::ex_mem_t               ex_mem,
	output cpu_pkg::dmem_req_t             dmem_req,
	input  logic [cpu_pkg::word_w-1:0]     dmem_rdata,
	output logic [cpu_pkg::word_w-1:0]     mem_fwd,
	output cpu_pkg::mem_wb_t               mem_wb,
	output logic [cpu_pkg::word_w-1:0]     wb_fwd,
	output logic                           wr_en,
	output logic [cpu_pkg::reg_addr_w-1:0] wr_addr,
	output logic [cpu_pkg::word_w-1:0]     wr_data,
	output logic [cpu_pkg::word_w-1:0]     num_inst,
	output logic [cpu_pkg::word_w-1:0]     output_port,
	output logic                           is_halted
);
	import cpu_pkg::*;

	ctrl_t                 ctrl_q;
	logic [word_w-1:0]     result_q;
	logic [word_w-1:0]     load_q;
	logic [word_w-1:0]     rs_val_q;
	logic [reg_addr_w-1:0] dest_q;
	logic                  halting;
	logic                  retire;

	// no memory traffic once HLT has reached WB
	assign halting = is_halted || (ctrl_q.valid && ctrl_q.is_halt);

	assign dmem_req.read       = ex_mem.ctrl.valid && ex_mem.ctrl.mem_read && !halting;
	assign dmem_req.write      = ex_mem.ctrl.valid && ex_mem.ctrl.mem_write && !halting;
	assign dmem_req.address    = ex_mem.alu_result;
	assign dmem_req.write_data = ex_mem.store_data;
	assign mem_fwd             = ex_mem.alu_result;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ctrl_q <= '0;
		else
			ctrl_q <= ex_mem.ctrl;
	end

	always_ff @(posedge clk) begin
		result_q <= ex_mem.alu_result;
		load_q   <= dmem_rdata;
		rs_val_q <= ex_mem.rs_val;
		dest_q   <= ex_mem.dest;
	end

	assign mem_wb = '{ctrl: ctrl_q, alu_result: result_q, load_data: load_q,
		rs_val: rs_val_q, dest: dest_q};

	assign wb_fwd  = ctrl_q.mem_read ? load_q : result_q;
	assign retire  = ctrl_q.valid && !is_halted;
	assign wr_en   = retire && ctrl_q.reg_write;
	assign wr_addr = dest_q;
	assign wr_data = wb_fwd;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			num_inst    <= '0;
			output_port <= '0;
			is_halted   <= 1'b0;
		end else if (retire) begin
			num_inst <= num_inst + 1'b1;
			if (ctrl_q.is_wwd)
				output_port <= rs_val_q;
			if (ctrl_q.is_halt)
				is_halted <= 1'b1; // sticky until reset
		end
	end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       flush,
	input  cpu_pkg::id_ex_t            id_ex,
	input  cpu_pkg::fwd_sel_e          fwd_a,
	input  cpu_pkg::fwd_sel_e          fwd_b,
	input  logic [cpu_pkg::word_w-1:0] mem_fwd,
	input  logic [cpu_pkg::word_w-1:0] wb_fwd,
	output cpu_pkg::ex_mem_t           ex_mem
);
	import cpu_pkg::*;

	logic [word_w-1:0]     op_a;
	logic [word_w-1:0]     op_b;
	logic [word_w-1:0]     alu_a;
	logic [word_w-1:0]     alu_b;
	logic [word_w-1:0]     alu_y;
	logic                  cond;
	logic                  taken_d;
	logic [word_w-1:0]     target_d;

	ctrl_t                 ctrl_q;
	logic                  taken_q;
	logic [word_w-1:0]     result_q;
	logic [word_w-1:0]     store_q;
	logic [word_w-1:0]     rs_val_q;
	logic [reg_addr_w-1:0] dest_q;
	logic [word_w-1:0]     target_q;

	always_comb begin
		case (fwd_a)
			fwd_mem: op_a = mem_fwd;
			fwd_wb:  op_a = wb_fwd;
			default: op_a = id_ex.rs_val;
		endcase
		case (fwd_b)
			fwd_mem: op_b = mem_fwd;
			fwd_wb:  op_b = wb_fwd;
			default: op_b = id_ex.rt_val;
		endcase
	end

	assign alu_a = id_ex.ctrl.a_zero ? '0 : op_a;
	assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			alu_add: alu_y = alu_a + alu_b;
			alu_sub: alu_y = alu_a - alu_b;
			alu_and: alu_y = alu_a & alu_b;
			alu_or:  alu_y = alu_a | alu_b;
			alu_not: alu_y = ~alu_a;
			alu_tcp: alu_y = ~alu_a + 1'b1;
			alu_shl: alu_y = alu_a << 1;
			default: alu_y = $signed(alu_a) >>> 1; // arithmetic shift
		endcase
	end

	// compare on the forwarded register values, never the immediate
	always_comb begin
		case (id_ex.ctrl.br_cond)
			br_ne:   cond = (op_a != op_b);
			br_eq:   cond = (op_a == op_b);
			br_gz:   cond = ($signed(op_a) > 0);
			default: cond = $signed(op_a) < 0;
		endcase
	end

	assign target_d = id_ex.ctrl.is_jump ? id_ex.imm : id_ex.pc + 1'b1 + id_ex.imm;
	assign taken_d  = id_ex.ctrl.valid &&
		(id_ex.ctrl.is_jump || (id_ex.ctrl.is_branch && cond));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_q  <= '0;
			taken_q <= 1'b0;
		end else if (flush) begin
			ctrl_q  <= '0;
			taken_q <= 1'b0;
		end else begin
			ctrl_q  <= id_ex.ctrl;
			taken_q <= taken_d;
		end
	end

	always_ff @(posedge clk) begin
		result_q <= alu_y;
		store_q  <= op_b;
		rs_val_q <= op_a; // for WWD
		dest_q   <= id_ex.dest;
		target_q <= target_d;
	end

	assign ex_mem = '{ctrl: ctrl_q, alu_result: result_q, store_data: store_q,
		rs_val: rs_val_q, dest: dest_q, taken: taken_q, target: target_q};

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           stall,
	input  logic                           flush,
	input  logic [cpu_pkg::word_w-1:0]     pc_id,
	input  logic [cpu_pkg::word_w-1:0]     inst_id,
	input  logic                           valid_id,
	output logic [cpu_pkg::reg_addr_w-1:0] rs,
	output logic [cpu_pkg::reg_addr_w-1:0] rt,
	output logic                           rs_used,
	output logic                           rt_used,
	input  logic [cpu_pkg::word_w-1:0]     rs_data,
	input  logic [cpu_pkg::word_w-1:0]     rt_data,
	output cpu_pkg::id_ex_t                id_ex
);
	import cpu_pkg::*;

	opcode_e               op;
	func_e                 fn;
	ctrl_t                 ctrl_d;
	logic [word_w-1:0]     imm_d;
	logic [reg_addr_w-1:0] dest_d;
	logic                  use_rs;
	logic                  use_rt;

	ctrl_t                 ctrl_q;
	logic [word_w-1:0]     pc_q;
	logic [reg_addr_w-1:0] rs_q;
	logic [reg_addr_w-1:0] rt_q;
	logic [word_w-1:0]     rs_val_q;
	logic [word_w-1:0]     rt_val_q;
	logic [word_w-1:0]     imm_q;
	logic [reg_addr_w-1:0] dest_q;

	assign op = opcode_e'(inst_id[15:12]);
	assign fn = func_e'(inst_id[5:0]);
	assign rs = inst_id[11:10];
	assign rt = inst_id[9:8];

	always_comb begin
		ctrl_d         = '0;
		ctrl_d.valid   = valid_id;
		ctrl_d.alu_op  = alu_add;
		ctrl_d.br_cond = br_cond_e'(inst_id[13:12]);
		imm_d          = {{8{inst_id[7]}}, inst_id[7:0]}; // sign extended by default
		dest_d         = rt;
		use_rs         = 1'b0;
		use_rt         = 1'b0;
		case (op)
			op_rtype: begin
				dest_d        = inst_id[7:6];
				use_rs        = 1'b1;
				ctrl_d.alu_op = alu_op_e'(inst_id[2:0]);
				case (fn)
					fn_add, fn_sub, fn_and, fn_orr: begin
						ctrl_d.reg_write = 1'b1;
						use_rt           = 1'b1;
					end
					fn_not, fn_tcp, fn_shl, fn_shr: ctrl_d.reg_write = 1'b1;
					fn_wwd: ctrl_d.is_wwd = 1'b1;
					fn_hlt: begin
						ctrl_d.is_halt = 1'b1;
						use_rs         = 1'b0;
					end
					default: use_rs = 1'b0; // unknown func retires as a nop
				endcase
			end
			op_adi, op_ori, op_lhi: begin
				ctrl_d.reg_write = 1'b1;
				ctrl_d.alu_src   = 1'b1;
				use_rs           = (op != op_lhi);
				if (op == op_ori) begin
					ctrl_d.alu_op = alu_or;
					imm_d         = {8'h00, inst_id[7:0]};
				end
				if (op == op_lhi) begin
					ctrl_d.a_zero = 1'b1;
					imm_d         = {inst_id[7:0], 8'h00};
				end
			end
			op_lwd, op_swd: begin
				ctrl_d.alu_src   = 1'b1;
				ctrl_d.mem_read  = (op == op_lwd);
				ctrl_d.reg_write = (op == op_lwd);
				ctrl_d.mem_write = (op == op_swd);
				use_rs           = 1'b1;
				use_rt           = (op == op_swd); // store data
			end
			op_bne, op_beq, op_bgz, op_blz: begin
				ctrl_d.is_branch = 1'b1;
				use_rs           = 1'b1;
				use_rt           = (op == op_bne || op == op_beq);
			end
			op_jmp: begin
				ctrl_d.is_jump = 1'b1;
				imm_d          = {pc_id[15:12], inst_id[11:0]}; // page of the jump
			end
			default: ;
		endcase
	end

	assign rs_used = valid_id && use_rs;
	assign rt_used = valid_id && use_rt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ctrl_q <= '0;
		else if (stall || flush)
			ctrl_q <= '0; // bubble
		else
			ctrl_q <= ctrl_d;
	end

	always_ff @(posedge clk) begin
		pc_q     <= pc_id;
		rs_q     <= rs;
		rt_q     <= rt;
		rs_val_q <= rs_data;
		rt_val_q <= rt_data;
		imm_q    <= imm_d;
		dest_q   <= dest_d;
	end

	assign id_ex = '{ctrl: ctrl_q, pc: pc_q, rs: rs_q, rt: rt_q, rs_val: rs_val_q,
		rt_val: rt_val_q, imm: imm_q, dest: dest_q};

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic [cpu_pkg::reg_addr_w-1:0] rs,
	input  logic [cpu_pkg::reg_addr_w-1:0] rt,
	output logic [cpu_pkg::word_w-1:0]     rs_data,
	output logic [cpu_pkg::word_w-1:0]     rt_data,
	input  logic                           wr_en,
	input  logic [cpu_pkg::reg_addr_w-1:0] wr_addr,
	input  logic [cpu_pkg::word_w-1:0]     wr_data
);
	import cpu_pkg::*;

	logic [word_w-1:0] regs [num_regs];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// write-through so WB and ID can share a cycle
	assign rs_data = (wr_en && wr_addr == rs) ? wr_data : regs[rs];
	assign rt_data = (wr_en && wr_addr == rt) ? wr_data : regs[rt];

endmodule

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       stall,
	input  logic                       flush,
	input  logic [cpu_pkg::word_w-1:0] redirect_pc,
	output logic                       imem_read,
	output logic [cpu_pkg::word_w-1:0] imem_addr,
	input  logic [cpu_pkg::word_w-1:0] imem_data,
	output logic [cpu_pkg::word_w-1:0] pc_id,
	output logic [cpu_pkg::word_w-1:0] inst_id,
	output logic                       valid_id
);
	import cpu_pkg::*;

	logic [word_w-1:0] pc;

	assign imem_read = arst_n; // fetching whenever out of reset
	assign imem_addr = pc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc       <= '0;
			valid_id <= 1'b0;
		end else if (flush) begin
			pc       <= redirect_pc;
			valid_id <= 1'b0;
		end else if (!stall) begin
			pc       <= pc + 1'b1;
			valid_id <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pc_id   <= pc;
			inst_id <= imem_data;
		end
	end

endmodule

//--- rtl/hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl (
	input  logic [cpu_pkg::reg_addr_w-1:0] rs_id,
	input  logic [cpu_pkg::reg_addr_w-1:0] rt_id,
	input  logic                           rs_used,
	input  logic                           rt_used,
	input  cpu_pkg::id_ex_t                id_ex,
	input  cpu_pkg::ex_mem_t               ex_mem,
	input  cpu_pkg::mem_wb_t               mem_wb,
	output logic                           stall,
	output logic                           flush,
	output cpu_pkg::fwd_sel_e              fwd_a,
	output cpu_pkg::fwd_sel_e              fwd_b
);
	import cpu_pkg::*;

	logic load_use;
	logic mem_wr;
	logic wb_wr;

	// newest producer wins
	function automatic fwd_sel_e pick(
		input logic [reg_addr_w-1:0] idx,
		input logic                  m_wr,
		input logic [reg_addr_w-1:0] m_dest,
		input logic                  w_wr,
		input logic [reg_addr_w-1:0] w_dest
	);
		if (m_wr && m_dest == idx)
			return fwd_mem;
		if (w_wr && w_dest == idx)
			return fwd_wb;
		return fwd_reg;
	endfunction

	assign mem_wr = ex_mem.ctrl.valid && ex_mem.ctrl.reg_write;
	assign wb_wr  = mem_wb.ctrl.valid && mem_wb.ctrl.reg_write;

	assign fwd_a = pick(id_ex.rs, mem_wr, ex_mem.dest, wb_wr, mem_wb.dest);
	assign fwd_b = pick(id_ex.rt, mem_wr, ex_mem.dest, wb_wr, mem_wb.dest);

	// load in EX, consumer in ID
	assign load_use = id_ex.ctrl.valid && id_ex.ctrl.mem_read &&
		((rs_used && rs_id == id_ex.dest) || (rt_used && rt_id == id_ex.dest));

	assign flush = ex_mem.ctrl.valid && ex_mem.taken;
	assign stall = load_use && !flush; // a redirect drops the waiting consumer anyway

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

	localparam int word_w     = 16;
	localparam int reg_addr_w = 2;
	localparam int num_regs   = 4;

	typedef enum logic [3:0] {
		op_bne   = 4'd0,
		op_beq   = 4'd1,
		op_bgz   = 4'd2,
		op_blz   = 4'd3,
		op_adi   = 4'd4,
		op_ori   = 4'd5,
		op_lhi   = 4'd6,
		op_lwd   = 4'd7,
		op_swd   = 4'd8,
		op_jmp   = 4'd9,
		op_rtype = 4'd15
	} opcode_e;

	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_not = 6'd4,
		fn_tcp = 6'd5,
		fn_shl = 6'd6,
		fn_shr = 6'd7,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} func_e;

	// same order as func 0..7
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_not,
		alu_tcp,
		alu_shl,
		alu_shr
	} alu_op_e;

	// same order as the branch opcodes
	typedef enum logic [1:0] {
		br_ne,
		br_eq,
		br_gz,
		br_lz
	} br_cond_e;

	typedef enum logic [1:0] {
		fwd_reg,
		fwd_mem,
		fwd_wb
	} fwd_sel_e;

	typedef struct packed {
		logic     valid;
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		logic     alu_src;   // operand b from the immediate
		logic     a_zero;    // operand a forced to zero, LHI
		logic     is_branch;
		logic     is_jump;
		logic     is_wwd;
		logic     is_halt;
		alu_op_e  alu_op;
		br_cond_e br_cond;
	} ctrl_t;

	typedef struct packed {
		ctrl_t                 ctrl;
		logic [word_w-1:0]     pc;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [word_w-1:0]     rs_val;
		logic [word_w-1:0]     rt_val;
		logic [word_w-1:0]     imm;
		logic [reg_addr_w-1:0] dest;
	} id_ex_t;

	typedef struct packed {
		ctrl_t                 ctrl;
		logic [word_w-1:0]     alu_result;
		logic [word_w-1:0]     store_data;
		logic [word_w-1:0]     rs_val;
		logic [reg_addr_w-1:0] dest;
		logic                  taken;
		logic [word_w-1:0]     target;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t                 ctrl;
		logic [word_w-1:0]     alu_result;
		logic [word_w-1:0]     load_data;
		logic [word_w-1:0]     rs_val;
		logic [reg_addr_w-1:0] dest;
	} mem_wb_t;

	typedef struct packed {
		logic              read;
		logic              write;
		logic [word_w-1:0] address;
		logic [word_w-1:0] write_data;
	} dmem_req_t;

endpackage
